// File: verilog/snakePkg.sv
package snakePkg;

    // playfield size in cells, coordinates run from 1
    localparam int boardW = 14;
    localparam int boardH = 10;

    localparam int maxObstacles = 25;

    // one cell address, packs into a byte as {x, y}
    typedef struct packed {
        logic [3:0] x;
        logic [3:0] y;
    } coordT;

    typedef enum logic [1:0] {
        dirUp,
        dirDown,
        dirLeft,
        dirRight
    } dirT;

    typedef enum logic {
        plIdle,
        plSearch
    } placerStateT;

    // true when (cx, cy) lies inside the walls
    function automatic logic inBoard(int cx, int cy);
        return (cx >= 1) && (cx <= boardW) && (cy >= 1) && (cy <= boardH);
    endfunction

    // row-major bit position in the obstacle map
    function automatic int cellIndex(int cx, int cy);
        return (cy - 1) * boardW + (cx - 1);
    endfunction

endpackage

// File: verilog/snakeBodyIf.sv
`timescale 1ns/1ns

interface snakeBodyIf
    import snakePkg::*;
#(
    parameter int MAX_LENGTH = 50
) ();

    localparam int lenW = $clog2(MAX_LENGTH + 1);

    // index 0 is the head
    coordT [MAX_LENGTH-1:0] body;
    logic [lenW-1:0]        length;

    coordT newHead;
    logic  advance;
    logic  grow;

    modport mover (
        output newHead,
        output advance,
        output grow,
        input  body,
        input  length
    );

    modport store (
        input  newHead,
        input  advance,
        input  grow,
        output body,
        output length
    );

    modport placer (
        input  body
    );

endinterface

// File: verilog/randCoord.sv
`timescale 1ns/1ns

module randCoord
    import snakePkg::*;
(
    input  logic       clk,
    input  logic       nRst,
    output logic [3:0] randX,
    output logic [3:0] randY
);

    logic [15:0] lfsr;
    logic [4:0]  rawX;
    logic [4:0]  rawY;

    // taps for x^16 + x^14 + x^13 + x^11 + 1
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            lfsr <= 16'hACE1;
        end else begin
            lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        end
    end

    // fold each nibble back into range by one subtraction
    always_comb begin
        rawX = {1'b0, lfsr[11:8]} + 5'd1;
        rawY = {1'b0, lfsr[3:0]} + 5'd1;
        if (rawX > 5'(boardW)) begin
            rawX = rawX - 5'(boardW);
        end
        if (rawY > 5'(boardH)) begin
            rawY = rawY - 5'(boardH);
        end
        randX = rawX[3:0];
        randY = rawY[3:0];
    end

    candInBoard: assert property (@(posedge clk) disable iff (!nRst)
        inBoard(int'(randX), int'(randY)));

endmodule

// File: verilog/snakeMover.sv
`timescale 1ns/1ns

module snakeMover
    import snakePkg::*;
(
    input  logic       clk,
    input  logic       nRst,
    input  logic       step,
    input  dirT        dir,
    input  logic [3:0] appleX,
    input  logic [3:0] appleY,
    snakeBodyIf.mover  bodyBus,
    output logic       goodColl,
    output logic       dead
);

    coordT head;
    coordT target;
    logic  hitWall;
    logic  hitBody;
    logic  hitApple;
    logic  legalStep;

    assign head = bodyBus.body[0];

    // neighbor cell of the head, may fall outside the board
    always_comb begin
        target = head;
        case (dir)
            dirUp: begin
                target.y = head.y - 4'd1;
            end
            dirDown: begin
                target.y = head.y + 4'd1;
            end
            dirLeft: begin
                target.x = head.x - 4'd1;
            end
            default: begin
                target.x = head.x + 4'd1;
            end
        endcase
    end

    // x and y never wrap past 0 or 15 from a legal head
    assign hitWall = !inBoard(int'(target.x), int'(target.y));

    // the tail leaves its cell on this same step, so it is skipped
    always_comb begin
        hitBody = 1'b0;
        for (int i = 0; i < bodyBus.MAX_LENGTH; i++) begin
            if ((i < int'(bodyBus.length) - 1) && (bodyBus.body[i] == target)) begin
                hitBody = 1'b1;
            end
        end
    end

    assign hitApple  = (target.x == appleX) && (target.y == appleY);
    assign legalStep = step && !dead && !hitWall && !hitBody;

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            bodyBus.advance <= 1'b0;
            bodyBus.grow    <= 1'b0;
            dead            <= 1'b0;
        end else begin
            bodyBus.advance <= legalStep;
            bodyBus.grow    <= legalStep && hitApple;
            if (step && !dead && (hitWall || hitBody)) begin
                dead <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (legalStep) begin
            bodyBus.newHead <= target;
        end
    end

    // the placer sees the same pulse that makes the body grow
    assign goodColl = bodyBus.grow;

    // once dead the store never shifts again
    noMoveWhenDead: assert property (@(posedge clk) disable iff (!nRst)
        dead |-> !bodyBus.advance);

endmodule

// File: verilog/bodyStore.sv
`timescale 1ns/1ns

module bodyStore
    import snakePkg::*;
#(
    parameter int MAX_LENGTH = 50
) (
    input  logic      clk,
    input  logic      nRst,
    snakeBodyIf.store bodyBus
);

    localparam int lenW = $clog2(MAX_LENGTH + 1);

    coordT [MAX_LENGTH-1:0] segs;
    logic [lenW-1:0]        len;
    logic [lenW-1:0]        nextLen;

    always_comb begin
        nextLen = len;
        if (bodyBus.grow && (len < lenW'(MAX_LENGTH))) begin
            nextLen = len + 1'b1;
        end
    end

    // starts as three cells lying left of the head
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            segs    <= '0;
            segs[0] <= '{x: 4'd3, y: 4'd5};
            segs[1] <= '{x: 4'd2, y: 4'd5};
            segs[2] <= '{x: 4'd1, y: 4'd5};
            len     <= lenW'(3);
        end else if (bodyBus.advance) begin
            segs[0] <= bodyBus.newHead;
            // cells past the new length read as 0
            for (int i = 1; i < MAX_LENGTH; i++) begin
                if (i < int'(nextLen)) begin
                    segs[i] <= segs[i-1];
                end else begin
                    segs[i] <= '0;
                end
            end
            len <= nextLen;
        end
    end

    assign bodyBus.body   = segs;
    assign bodyBus.length = len;

    lengthRange: assert property (@(posedge clk) disable iff (!nRst)
        (int'(len) >= 3) && (int'(len) <= MAX_LENGTH));

endmodule

// File: verilog/obstaclePlacer.sv
`timescale 1ns/1ns

module obstaclePlacer
    import snakePkg::*;
#(
    parameter int MAX_LENGTH = 50
) (
    input  logic       clk,
    input  logic       nRst,
    input  logic       obstacleFlag,
    input  logic       goodColl,
    input  logic [3:0] randX,
    input  logic [3:0] randY,
    input  logic [3:0] x,
    input  logic [3:0] y,
    snakeBodyIf.placer bodyBus,
    output logic       obstacle,
    output logic [4:0] obstacleCount
);

    localparam int cells = boardW * boardH;

    placerStateT      state;
    logic [cells-1:0] occMap;
    coordT            cand;
    coordT            head;
    logic             onBody;
    logic             besideHead;
    logic             crowded;
    logic             legal;

    // off-board cells count as free
    function automatic logic occupied(logic [cells-1:0] m, int cx, int cy);
        if (!inBoard(cx, cy)) begin
            return 1'b0;
        end
        return m[cellIndex(cx, cy)];
    endfunction

    assign cand = '{x: randX, y: randY};
    assign head = bodyBus.body[0];

    // unused segments are 0 and never match an in-range candidate
    always_comb begin
        onBody = 1'b0;
        for (int i = 0; i < MAX_LENGTH; i++) begin
            if (bodyBus.body[i] == cand) begin
                onBody = 1'b1;
            end
        end
    end

    assign besideHead =
        ((cand.x == head.x) && ((cand.y == head.y + 4'd1) || (cand.y + 4'd1 == head.y))) ||
        ((cand.y == head.y) && ((cand.x == head.x + 4'd1) || (cand.x + 4'd1 == head.x)));

    // the cell itself and all eight neighbors must be clear
    always_comb begin
        crowded = 1'b0;
        for (int dx = -1; dx <= 1; dx++) begin
            for (int dy = -1; dy <= 1; dy++) begin
                if (occupied(occMap, int'(randX) + dx, int'(randY) + dy)) begin
                    crowded = 1'b1;
                end
            end
        end
    end

    assign legal = !onBody && !besideHead && !crowded;

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state         <= plIdle;
            occMap        <= '0;
            obstacleCount <= '0;
        end else if (!obstacleFlag) begin
            state         <= plIdle;
            occMap        <= '0;
            obstacleCount <= '0;
        end else begin
            case (state)
                plIdle: begin
                    // requests while searching are simply lost
                    if (goodColl && (obstacleCount < 5'(maxObstacles))) begin
                        state <= plSearch;
                    end
                end
                default: begin
                    if (legal) begin
                        occMap[cellIndex(int'(randX), int'(randY))] <= 1'b1;
                        obstacleCount <= obstacleCount + 5'd1;
                        state         <= plIdle;
                    end
                end
            endcase
        end
    end

    // point query for the display side, one cycle late
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            obstacle <= 1'b0;
        end else begin
            obstacle <= obstacleFlag && occupied(occMap, int'(x), int'(y));
        end
    end

    countLimit: assert property (@(posedge clk) disable iff (!nRst)
        obstacleCount <= 5'(maxObstacles));

endmodule

// File: verilog/snakeCore.sv
`timescale 1ns/1ns

module snakeCore
    import snakePkg::*;
#(
    parameter int MAX_LENGTH = 50
) (
    input  logic                             clk,
    input  logic                             nRst,
    input  logic                             step,
    input  dirT                              dir,
    input  logic [3:0]                       appleX,
    input  logic [3:0]                       appleY,
    input  logic                             obstacleFlag,
    input  logic [3:0]                       x,
    input  logic [3:0]                       y,
    output logic                             obstacle,
    output logic [3:0]                       headX,
    output logic [3:0]                       headY,
    output logic [$clog2(MAX_LENGTH + 1)-1:0] length,
    output logic                             dead,
    output logic [4:0]                       obstacleCount
);

    logic [3:0] randX;
    logic [3:0] randY;
    logic       goodColl;

    snakeBodyIf #(.MAX_LENGTH(MAX_LENGTH)) bodyBus ();

    randCoord uRand (
        .clk   (clk),
        .nRst  (nRst),
        .randX (randX),
        .randY (randY)
    );

    snakeMover uMover (
        .clk      (clk),
        .nRst     (nRst),
        .step     (step),
        .dir      (dir),
        .appleX   (appleX),
        .appleY   (appleY),
        .bodyBus  (bodyBus.mover),
        .goodColl (goodColl),
        .dead     (dead)
    );

    bodyStore #(.MAX_LENGTH(MAX_LENGTH)) uStore (
        .clk     (clk),
        .nRst    (nRst),
        .bodyBus (bodyBus.store)
    );

    obstaclePlacer #(.MAX_LENGTH(MAX_LENGTH)) uPlacer (
        .clk           (clk),
        .nRst          (nRst),
        .obstacleFlag  (obstacleFlag),
        .goodColl      (goodColl),
        .randX         (randX),
        .randY         (randY),
        .x             (x),
        .y             (y),
        .bodyBus       (bodyBus.placer),
        .obstacle      (obstacle),
        .obstacleCount (obstacleCount)
    );

    assign headX  = bodyBus.body[0].x;
    assign headY  = bodyBus.body[0].y;
    assign length = bodyBus.length;

endmodule

// File: bench/clockGen.sv
`timescale 1ns/1ns

module clockGen #(
    parameter int period      = 40,
    parameter int resetCycles = 5
) (
    output logic clk,
    output logic nRst
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        nRst = 1'b0;
        repeat (resetCycles) @(posedge clk);
        #2 nRst = 1'b1;
    end

endmodule

// File: bench/snakeTb.sv
`timescale 1ns/1ns

module snakeTb
    import snakePkg::*;
();

    localparam int maxLen     = 50;
    localparam int lenW       = $clog2(maxLen + 1);
    localparam int cellCount  = boardW * boardH;
    localparam int placeBound = 3000;
    // cycle budget covers two-cycle steps, one-cycle map reads per cell and worst-case placements
    localparam int numSteps   = 12 + 5 + 30 * 3 + 4;
    localparam int numReads   = 32;
    localparam int runCycles  = 10 + numSteps * 2 + numReads * cellCount + 30 * placeBound;
    localparam int watchdogCycles = 2 * runCycles;

    logic            clk;
    logic            nRst;
    logic            step;
    dirT             dir;
    logic [3:0]      appleX;
    logic [3:0]      appleY;
    logic            obstacleFlag;
    logic [3:0]      x;
    logic [3:0]      y;
    logic            obstacle;
    logic [3:0]      headX;
    logic [3:0]      headY;
    logic [lenW-1:0] length;
    logic            dead;
    logic [4:0]      obstacleCount;

    // reference model of the snake with the head at index 0
    coordT                body[$];
    logic                 modelDead;
    logic [cellCount-1:0] knownMap;

    clockGen #(.period(40), .resetCycles(5)) uClk (.clk(clk), .nRst(nRst));

    snakeCore #(.MAX_LENGTH(maxLen)) dut (
        .clk           (clk),
        .nRst          (nRst),
        .step          (step),
        .dir           (dir),
        .appleX        (appleX),
        .appleY        (appleY),
        .obstacleFlag  (obstacleFlag),
        .x             (x),
        .y             (y),
        .obstacle      (obstacle),
        .headX         (headX),
        .headY         (headY),
        .length        (length),
        .dead          (dead),
        .obstacleCount (obstacleCount)
    );

    task automatic abortRun(string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic checkCoord(string name, coordT exp, coordT act);
        if (act !== exp) begin
            abortRun($sformatf("Fail %s: expected 0x%h, got 0x%h", name, exp, act));
        end
    endtask

    task automatic checkLength(string name, logic [lenW-1:0] exp, logic [lenW-1:0] act);
        if (act !== exp) begin
            abortRun($sformatf("Fail %s: expected 0x%h, got 0x%h", name, exp, act));
        end
    endtask

    task automatic checkBit(string name, logic exp, logic act);
        if (act !== exp) begin
            abortRun($sformatf("Fail %s: expected 0x%h, got 0x%h", name, exp, act));
        end
    endtask

    task automatic checkCount(string name, logic [4:0] exp, logic [4:0] act);
        if (act !== exp) begin
            abortRun($sformatf("Fail %s: expected 0x%h, got 0x%h", name, exp, act));
        end
    endtask

    function automatic coordT at(int cx, int cy);
        coordT c;
        c.x = 4'(cx);
        c.y = 4'(cy);
        return c;
    endfunction

    function automatic logic insideWalls(int cx, int cy);
        return cx >= 1 && cx <= boardW && cy >= 1 && cy <= boardH;
    endfunction

    function automatic coordT nextCell(coordT c, dirT d);
        int cx;
        int cy;
        cx = c.x;
        cy = c.y;
        case (d)
            dirUp: cy--;
            dirDown: cy++;
            dirLeft: cx--;
            default: cx++;
        endcase
        return at(cx, cy);
    endfunction

    // closed tour where column 1 runs up and rows 1 to 10 snake between columns 2 and 14
    function automatic dirT cycleDir(coordT c);
        if (c.x == 4'd1) begin
            return (c.y == 4'd1) ? dirRight : dirUp;
        end
        if (c.y[0]) begin
            return (c.x < 4'(boardW)) ? dirRight : dirDown;
        end
        if (c.x > 4'd2) begin
            return dirLeft;
        end
        return (c.y < 4'(boardH)) ? dirDown : dirLeft;
    endfunction

    task automatic modelStep(dirT d, coordT apple);
        int   tx;
        int   ty;
        logic hit;
        logic eat;
        coordT t;
        tx = body[0].x;
        ty = body[0].y;
        case (d)
            dirUp: ty--;
            dirDown: ty++;
            dirLeft: tx--;
            default: tx++;
        endcase
        t = at(tx, ty);
        hit = !insideWalls(tx, ty);
        // the tail cell is vacated on the same step
        for (int i = 0; i < body.size() - 1; i++) begin
            if (body[i] == t) begin
                hit = 1'b1;
            end
        end
        if (modelDead) begin
            return;
        end
        if (hit) begin
            modelDead = 1'b1;
        end else begin
            eat = (t == apple) && (body.size() < maxLen);
            body.push_front(t);
            if (!eat) begin
                void'(body.pop_back());
            end
        end
    endtask

    // starts and ends 2 ns after a rising edge
    task automatic doStep(dirT d, logic eat);
        coordT apple;
        apple = eat ? nextCell(body[0], d) : at(0, 0);
        step   = 1'b1;
        dir    = d;
        appleX = apple.x;
        appleY = apple.y;
        @(posedge clk);
        #2;
        step   = 1'b0;
        appleX = 4'd0;
        appleY = 4'd0;
        @(posedge clk);
        #2;
        modelStep(d, apple);
        checkCoord("head", body[0], at(headX, headY));
        checkLength("length", lenW'(body.size()), length);
        checkBit("dead", modelDead, dead);
        checkCoord("tail", body[body.size()-1], dut.bodyBus.body[body.size()-1]);
    endtask

    task automatic cycleStep(logic eat);
        doStep(cycleDir(body[0]), eat);
    endtask

    task automatic readMap(output logic [cellCount-1:0] m);
        for (int i = 0; i < cellCount; i++) begin
            x = 4'(i % boardW + 1);
            y = 4'(i / boardW + 1);
            @(posedge clk);
            #2;
            m[i] = obstacle;
        end
    endtask

    task automatic checkPlacement(logic [cellCount-1:0] newMap);
        logic [cellCount-1:0] added;
        int    idx;
        int    dx;
        int    dy;
        coordT c;
        added = newMap & ~knownMap;
        idx = 0;
        if ((newMap & knownMap) != knownMap) begin
            abortRun("an earlier obstacle vanished from the map");
        end
        if ($countones(added) != 1) begin
            abortRun("a placement did not add exactly one obstacle");
        end
        checkCount("obstacleCount", 5'($countones(newMap)), obstacleCount);
        for (int i = 0; i < cellCount; i++) begin
            if (added[i]) begin
                idx = i;
            end
        end
        c = at(idx % boardW + 1, idx / boardW + 1);
        foreach (body[i]) begin
            if (body[i] == c) begin
                abortRun("new obstacle was placed on the snake body");
            end
        end
        dx = int'(c.x) - int'(body[0].x);
        dy = int'(c.y) - int'(body[0].y);
        if (dx * dx + dy * dy == 1) begin
            abortRun("new obstacle was placed next to the head");
        end
        for (int nx = -1; nx <= 1; nx++) begin
            for (int ny = -1; ny <= 1; ny++) begin
                dx = int'(c.x) + nx;
                dy = int'(c.y) + ny;
                if ((nx != 0 || ny != 0) && insideWalls(dx, dy)
                        && newMap[(dy - 1) * boardW + dx - 1]) begin
                    abortRun("new obstacle touches another obstacle");
                end
            end
        end
    endtask

    // eat one apple and wait for the placer to finish
    task automatic placeOne();
        logic [cellCount-1:0] newMap;
        logic [4:0]           prev;
        int                   waited;
        repeat ($urandom % 3) cycleStep(1'b0);
        prev = obstacleCount;
        cycleStep(1'b1);
        waited = 0;
        while (obstacleCount == prev) begin
            if (waited == placeBound) begin
                abortRun("obstacle request did not complete within the cycle bound");
            end
            @(posedge clk);
            #2;
            waited++;
        end
        checkCount("obstacleCount", prev + 5'd1, obstacleCount);
        readMap(newMap);
        checkPlacement(newMap);
        knownMap = newMap;
    endtask

    task automatic resetAndMove();
        checkCoord("head", at(3, 5), at(headX, headY));
        checkLength("length", lenW'(3), length);
        checkBit("dead", 1'b0, dead);
        checkCount("obstacleCount", 5'd0, obstacleCount);
        repeat (12) cycleStep(1'b0);
    endtask

    task automatic growth();
        cycleStep(1'b1);
        checkLength("length", lenW'(4), length);
        repeat (4) cycleStep(1'b0);
    endtask

    task automatic obstaclePlacement();
        logic [cellCount-1:0] m;
        obstacleFlag = 1'b1;
        @(posedge clk);
        #2;
        readMap(m);
        checkCount("map population", 5'd0, 5'($countones(m)));
        knownMap = '0;
        repeat (10) placeOne();
    endtask

    task automatic limitAndClear();
        logic [cellCount-1:0] m;
        int                   idx;
        idx = 0;
        while (obstacleCount < 5'(maxObstacles)) begin
            placeOne();
        end
        repeat (3) begin
            cycleStep(1'b1);
            repeat (4) @(posedge clk);
            #2;
            checkCount("obstacleCount", 5'(maxObstacles), obstacleCount);
            readMap(m);
            if (m !== knownMap) begin
                abortRun("obstacle map changed after the limit was reached");
            end
        end
        for (int i = 0; i < cellCount; i++) begin
            if (knownMap[i]) begin
                idx = i;
            end
        end
        // park the query on a placed obstacle while the flag drops
        x = 4'(idx % boardW + 1);
        y = 4'(idx / boardW + 1);
        obstacleFlag = 1'b0;
        @(posedge clk);
        #2;
        checkBit("obstacle", 1'b0, obstacle);
        obstacleFlag = 1'b1;
        checkCount("obstacleCount", 5'd0, obstacleCount);
        readMap(m);
        for (int i = 0; i < cellCount; i++) begin
            checkBit("obstacle", 1'b0, m[i]);
        end
    endtask

    task automatic death();
        coordT h;
        coordT back;
        dirT   rev;
        h = body[0];
        back = body[1];
        if (back.x != h.x) begin
            rev = (back.x < h.x) ? dirLeft : dirRight;
        end else begin
            rev = (back.y < h.y) ? dirUp : dirDown;
        end
        doStep(rev, 1'b0);
        checkBit("dead", 1'b1, dead);
        repeat (3) cycleStep(1'b0);
        checkCoord("head", h, at(headX, headY));
    endtask

    initial begin
        step         = 1'b0;
        dir          = dirRight;
        appleX       = 4'd0;
        appleY       = 4'd0;
        obstacleFlag = 1'b0;
        x            = 4'd1;
        y            = 4'd1;
        modelDead    = 1'b0;
        knownMap     = '0;
        void'($urandom(76305));
        body.push_back(at(3, 5));
        body.push_back(at(2, 5));
        body.push_back(at(1, 5));
        wait (nRst === 1'b1);
        @(posedge clk);
        #2;
        resetAndMove();
        growth();
        obstaclePlacement();
        limitAndClear();
        // the snake cannot recover, so this runs last
        death();
        $display("STATUS: PASS");
        $finish;
    end

    initial begin
        repeat (watchdogCycles) @(posedge clk);
        abortRun("timeout: the tests did not finish within the allowed number of cycles");
    end

endmodule

// File: tb.f
verilog/snakePkg.sv
verilog/snakeBodyIf.sv
verilog/randCoord.sv
verilog/snakeMover.sv
verilog/bodyStore.sv
verilog/obstaclePlacer.sv
verilog/snakeCore.sv
bench/clockGen.sv
bench/snakeTb.sv

// File: Bender.yml
package:
  name: snake_core

sources:
  - verilog/snakePkg.sv
  - verilog/snakeBodyIf.sv
  - verilog/randCoord.sv
  - verilog/snakeMover.sv
  - verilog/bodyStore.sv
  - verilog/obstaclePlacer.sv
  - verilog/snakeCore.sv
  - target: test
    files:
      - bench/clockGen.sv
      - bench/snakeTb.sv
